/* bench/clk_gen.sv */
module clk_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    logic power_on;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        power_on = 1'b1;
        repeat (3) @(posedge clk);
        power_on <= 1'b0;
    end

    assign rst = power_on | reset_req;

endmodule

/* bench/tb_omok.sv */
module tb_omok
    import omok_board_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int hold_cycles  = 2;
    localparam int idle_cycles  = 2;
    localparam int win_timeout  = 20;
    localparam int random_steps = 80;
    localparam int arm_dr [4] = '{0, 0, -1, 1};
    localparam int arm_dc [4] = '{1, -1, 0, 0};
    localparam int line_dr [4] = '{0, 1, 1, 1};
    localparam int line_dc [4] = '{1, 0, 1, -1};

    logic clk, rst, reset_req;
    logic btn_left, btn_right, btn_up, btn_down, put;
    pos_t cursor_pos;
    board_t board;
    logic [6:0] move_count;
    logic black_win, white_win;

    pos_t m_cur; // model state
    board_t m_board;
    logic [6:0] m_count;
    logic m_bwin, m_wwin;
    integer seed;
    int errors;

    clk_gen u_clk_gen (.reset_req(reset_req), .clk(clk), .rst(rst));

    omok_top u_omok_top (
        .clk(clk), .rst(rst), .btn_left(btn_left), .btn_right(btn_right),
        .btn_up(btn_up), .btn_down(btn_down), .put(put), .cursor_pos(cursor_pos),
        .board(board), .move_count(move_count), .black_win(black_win), .white_win(white_win)
    );

    function automatic logic own_at(int r, int c, logic w);
        if (r < 0 || r >= board_dim || c < 0 || c >= board_dim) begin
            return 1'b0;
        end
        return m_board[r * board_dim + c].code == (w ? cell_white : cell_black);
    endfunction

    function automatic logic empty_at(int r, int c);
        if (r < 0 || r >= board_dim || c < 0 || c >= board_dim) begin
            return 1'b0;
        end
        return m_board[r * board_dim + c].code == cell_empty;
    endfunction

    // double three means two arms of own own empty
    function automatic logic is_forbidden(pos_t p, logic w);
        int r;
        int c;
        int hits;
        r = int'(p) / board_dim;
        c = int'(p) % board_dim;
        hits = 0;
        if (r < 3 || r > 6 || c < 3 || c > 6) begin
            return 1'b0;
        end
        for (int d = 0; d < 4; d++) begin
            if (own_at(r + arm_dr[d], c + arm_dc[d], w)
                && own_at(r + 2 * arm_dr[d], c + 2 * arm_dc[d], w)
                && empty_at(r + 3 * arm_dr[d], c + 3 * arm_dc[d])) begin
                hits++;
            end
        end
        return hits == 2;
    endfunction

    function automatic logic makes_five(pos_t p, logic w);
        int r;
        int c;
        int n;
        int k;
        r = int'(p) / board_dim;
        c = int'(p) % board_dim;
        for (int d = 0; d < 4; d++) begin
            n = 1;
            k = 1;
            while (own_at(r + k * line_dr[d], c + k * line_dc[d], w)) k++;
            n = n + k - 1;
            k = 1;
            while (own_at(r - k * line_dr[d], c - k * line_dc[d], w)) k++;
            n = n + k - 1;
            if (n >= 5) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic fail_now(string what);
        errors++;
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "test stopped");
    endtask

    task automatic check_pos(string name, pos_t exp, pos_t act);
        if (exp !== act) begin
            fail_now($sformatf("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_board(string name, board_t exp, board_t act);
        if (exp !== act) begin
            fail_now($sformatf("** Error at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_count(string name, logic [6:0] exp, logic [6:0] act);
        if (exp !== act) begin
            fail_now($sformatf("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            fail_now($sformatf("** Error at %0t: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic compare_all();
        int n;
        n = 0;
        while ((black_win !== m_bwin || white_win !== m_wwin) && n < win_timeout) begin
            @(negedge clk);
            n++;
        end
        if (black_win !== m_bwin || white_win !== m_wwin) begin
            fail_now("Timeout: win flags did not reach the expected state within 20 cycles");
        end
        check_pos("cursor_pos", m_cur, cursor_pos);
        check_board("board", m_board, board);
        check_count("move_count", m_count, move_count);
        check_flag("black_win", m_bwin, black_win);
        check_flag("white_win", m_wwin, white_win);
    endtask

    task automatic model_act(int which);
        int r;
        int c;
        r = int'(m_cur) / board_dim;
        c = int'(m_cur) % board_dim;
        case (which)
            0: if (c < board_dim - 1) m_cur = m_cur + 7'd1;
            1: if (c > 0) m_cur = m_cur - 7'd1;
            2: if (r > 0) m_cur = m_cur - 7'd10;
            3: if (r < board_dim - 1) m_cur = m_cur + 7'd10;
            default: begin
                if (!m_bwin && !m_wwin && m_board[m_cur].code == cell_empty
                    && !is_forbidden(m_cur, m_count[0])) begin
                    m_board[m_cur].code = m_count[0] ? cell_white : cell_black;
                    if (makes_five(m_cur, m_count[0])) begin
                        if (m_count[0]) m_wwin = 1'b1;
                        else m_bwin = 1'b1;
                    end
                    m_count = m_count + 7'd1;
                end
            end
        endcase
    endtask

    // 0 right, 1 left, 2 up, 3 down, 4 put
    task automatic step(int which, int hold);
        @(posedge clk);
        case (which)
            0: btn_right <= 1'b1;
            1: btn_left <= 1'b1;
            2: btn_up <= 1'b1;
            3: btn_down <= 1'b1;
            default: put <= 1'b1;
        endcase
        repeat (hold) @(posedge clk);
        btn_right <= 1'b0;
        btn_left  <= 1'b0;
        btn_up    <= 1'b0;
        btn_down  <= 1'b0;
        put       <= 1'b0;
        repeat (idle_cycles) @(posedge clk);
        model_act(which);
        @(negedge clk);
        compare_all();
    endtask

    task automatic goto(pos_t t);
        while (int'(m_cur) % board_dim < int'(t) % board_dim) step(0, hold_cycles);
        while (int'(m_cur) % board_dim > int'(t) % board_dim) step(1, hold_cycles);
        while (int'(m_cur) / board_dim > int'(t) / board_dim) step(2, hold_cycles);
        while (int'(m_cur) / board_dim < int'(t) / board_dim) step(3, hold_cycles);
    endtask

    task automatic place_at(pos_t t);
        goto(t);
        step(4, hold_cycles);
    endtask

    task automatic apply_reset();
        int n;
        @(posedge clk);
        reset_req <= 1'b1;
        repeat (3) @(posedge clk);
        reset_req <= 1'b0;
        m_cur   = cursor_home;
        m_board = '0;
        m_count = 7'd0;
        m_bwin  = 1'b0;
        m_wwin  = 1'b0;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            fail_now("Timeout: reset did not release");
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_all();
    endtask

    // the mover runs a line from b0 while the other side fills row 9
    task automatic play_line(int b0, int stride);
        for (int k = 0; k < 5; k++) begin
            place_at(pos_t'(b0 + k * stride));
            if (k < 4) place_at(pos_t'(90 + 2 * k));
        end
        place_at(7'd50); // frozen board
    endtask

    initial begin
        int choice;
        seed = 2;
        errors = 0;
        reset_req = 1'b0;
        btn_left = 1'b0;
        btn_right = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        put = 1'b0;
        apply_reset();
        goto(7'd0);
        step(2, hold_cycles);
        step(1, hold_cycles);
        goto(7'd99);
        step(3, hold_cycles);
        step(0, hold_cycles);
        goto(7'd55);
        step(0, 6); // held button moves once
        place_at(7'd55);
        place_at(7'd57);
        place_at(7'd55);
        place_at(7'd58);
        apply_reset();
        place_at(7'd45);
        place_at(7'd0);
        place_at(7'd46);
        place_at(7'd9);
        place_at(7'd54);
        place_at(7'd90);
        place_at(7'd64);
        place_at(7'd99);
        place_at(7'd44);
        apply_reset();
        place_at(7'd12);
        place_at(7'd90);
        place_at(7'd13);
        place_at(7'd92);
        place_at(7'd21);
        place_at(7'd94);
        place_at(7'd31);
        place_at(7'd96);
        place_at(7'd11);
        apply_reset();
        play_line(0, 1);
        apply_reset();
        play_line(7, 10);
        apply_reset();
        play_line(0, 11);
        apply_reset();
        play_line(9, 9);
        apply_reset();
        place_at(7'd98); // black opens so white owns the line
        play_line(0, 1);
        apply_reset();
        for (int i = 0; i < random_steps; i++) begin
            choice = {$random(seed)} % 10;
            if (choice < 4) begin
                step(choice, hold_cycles);
            end else if (choice < 6) begin
                step(4, hold_cycles);
            end else begin
                step({$random(seed)} % 4, hold_cycles);
                step(4, hold_cycles);
            end
        end
        apply_reset();
        step(4, hold_cycles);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* common/omok_board_pkg.sv */
package omok_board_pkg;

    localparam int board_dim  = 10;
    localparam int cell_count = board_dim * board_dim;

    // row * board_dim + col
    typedef logic [6:0] pos_t;

    localparam pos_t cursor_home = 7'd44;

    localparam logic [1:0] cell_empty = 2'b00;
    localparam logic [1:0] cell_black = 2'b10;
    localparam logic [1:0] cell_white = 2'b11;

    typedef struct packed {
        logic occupied;
        logic white;
    } cell_bits_t;

    // same two bits, seen as a code or as flags
    typedef union packed {
        logic [1:0] code;
        cell_bits_t bits;
    } cell_t;

    typedef cell_t [cell_count-1:0] board_t;

endpackage

/* common/omok_rules_pkg.sv */
package omok_rules_pkg;

    // stones in a line needed to win
    localparam int win_len = 5;

    // double three: own, own, empty along one arm
    localparam int arm_len        = 3;
    localparam int forbidden_arms = 2;

    // rule only applies inside this row/col window
    localparam int check_lo = 3;
    localparam int check_hi = 6;

endpackage

/* rtl/board_store.sv */
module board_store
    import omok_board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       put,
    input  pos_t       cursor_pos,
    input  logic       forbidden,
    input  logic       black_win,
    input  logic       white_win,
    output board_t     board,
    output logic [6:0] move_count,
    output logic       white_to_move,
    output logic       placed,
    output pos_t       placed_pos
);

    logic put_prev;
    logic cell_free;
    logic accept;

    assign cell_free     = board[cursor_pos].code == cell_empty;
    assign white_to_move = move_count[0]; // black on even counts

    // latched win flags keep the board frozen until reset
    assign accept = put && !put_prev && cell_free && !forbidden
                    && !black_win && !white_win;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            put_prev   <= 1'b0;
            board      <= '0;
            move_count <= 7'd0;
            placed     <= 1'b0;
        end else begin
            put_prev <= put;
            placed   <= accept; // single cycle pulse
            if (accept) begin
                board[cursor_pos].code <= move_count[0] ? cell_white : cell_black;
                move_count             <= move_count + 7'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            placed_pos <= cursor_pos;
        end
    end

endmodule

/* rtl/cursor_ctrl.sv */
module cursor_ctrl
    import omok_board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic btn_left,
    input  logic btn_right,
    input  logic btn_up,
    input  logic btn_down,
    output pos_t cursor_pos
);

    logic left_prev, right_prev, up_prev, down_prev;
    logic [3:0] row, col;

    assign row = 4'(cursor_pos / board_dim);
    assign col = 4'(cursor_pos % board_dim);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_prev  <= 1'b0;
            right_prev <= 1'b0;
            up_prev    <= 1'b0;
            down_prev  <= 1'b0;
            cursor_pos <= cursor_home;
        end else begin
            left_prev  <= btn_left;
            right_prev <= btn_right;
            up_prev    <= btn_up;
            down_prev  <= btn_down;
            // right wins over left, up, down
            if (btn_right && !right_prev && col != 4'(board_dim - 1)) begin
                cursor_pos <= cursor_pos + 7'd1;
            end else if (btn_left && !left_prev && col != 4'd0) begin
                cursor_pos <= cursor_pos - 7'd1;
            end else if (btn_up && !up_prev && row != 4'd0) begin
                cursor_pos <= cursor_pos - pos_t'(board_dim); // one row up
            end else if (btn_down && !down_prev && row != 4'(board_dim - 1)) begin
                cursor_pos <= cursor_pos + pos_t'(board_dim);
            end
        end
    end

endmodule

/* rtl/omok_top.sv */
module omok_top
    import omok_board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       btn_left,
    input  logic       btn_right,
    input  logic       btn_up,
    input  logic       btn_down,
    input  logic       put,
    output pos_t       cursor_pos,
    output board_t     board,
    output logic [6:0] move_count,
    output logic       black_win,
    output logic       white_win
);

    logic white_to_move;
    logic placed;
    pos_t placed_pos;
    logic forbidden;

    cursor_ctrl u_cursor (
        .clk        (clk),
        .rst        (rst),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .cursor_pos (cursor_pos)
    );

    board_store u_board (
        .clk           (clk),
        .rst           (rst),
        .put           (put),
        .cursor_pos    (cursor_pos),
        .forbidden     (forbidden),
        .black_win     (black_win),
        .white_win     (white_win),
        .board         (board),
        .move_count    (move_count),
        .white_to_move (white_to_move),
        .placed        (placed),
        .placed_pos    (placed_pos)
    );

    forbidden_checker u_forbid (
        .clk           (clk),
        .rst           (rst),
        .board         (board),
        .cursor_pos    (cursor_pos),
        .white_to_move (white_to_move),
        .forbidden     (forbidden)
    );

    win_detector u_win (
        .clk        (clk),
        .rst        (rst),
        .board      (board),
        .placed     (placed),
        .placed_pos (placed_pos),
        .black_win  (black_win),
        .white_win  (white_win)
    );

endmodule

/* rules/forbidden_checker.sv */
module forbidden_checker
    import omok_board_pkg::*;
    import omok_rules_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  board_t board,
    input  pos_t   cursor_pos,
    input  logic   white_to_move,
    output logic   forbidden
);

    logic [3:0] row, col;
    logic       in_bounds;
    logic       arm_r, arm_l, arm_u, arm_d;
    logic [2:0] arm_cnt;

    // own stones first and an empty cell at the far end
    function automatic logic arm_match(board_t b, pos_t p, int dr, int dc, logic w);
        int r;
        int c;
        int k;
        logic ok;
        r  = int'(p) / board_dim;
        c  = int'(p) % board_dim;
        ok = 1'b1;
        for (k = 1; k <= arm_len; k++) begin
            r = r + dr;
            c = c + dc;
            if (r < 0 || r >= board_dim || c < 0 || c >= board_dim) begin
                ok = 1'b0;
            end else if (k < arm_len) begin
                ok = ok && b[r * board_dim + c].bits.occupied
                        && b[r * board_dim + c].bits.white == w;
            end else begin
                ok = ok && !b[r * board_dim + c].bits.occupied;
            end
        end
        return ok;
    endfunction

    assign row       = 4'(cursor_pos / board_dim);
    assign col       = 4'(cursor_pos % board_dim);
    assign in_bounds = row >= 4'(check_lo) && row <= 4'(check_hi)
                       && col >= 4'(check_lo) && col <= 4'(check_hi);

    assign arm_r   = arm_match(board, cursor_pos, 0, 1, white_to_move);
    assign arm_l   = arm_match(board, cursor_pos, 0, -1, white_to_move);
    assign arm_u   = arm_match(board, cursor_pos, -1, 0, white_to_move);
    assign arm_d   = arm_match(board, cursor_pos, 1, 0, white_to_move);
    assign arm_cnt = 3'(arm_r) + 3'(arm_l) + 3'(arm_u) + 3'(arm_d);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            forbidden <= 1'b0;
        end else begin
            forbidden <= in_bounds && arm_cnt == 3'(forbidden_arms); // exactly two arms
        end
    end

endmodule

/* rules/win_detector.sv */
module win_detector
    import omok_board_pkg::*;
    import omok_rules_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  board_t board,
    input  logic   placed,
    input  pos_t   placed_pos,
    output logic   black_win,
    output logic   white_win
);

    logic stone_white;
    logic win_hit;

    // same colour stones walking away from p, stops at edge or gap
    function automatic int side_run(board_t b, pos_t p, int dr, int dc, logic w);
        int r;
        int c;
        int n;
        int k;
        logic go;
        r  = int'(p) / board_dim;
        c  = int'(p) % board_dim;
        n  = 0;
        go = 1'b1;
        for (k = 1; k < win_len; k++) begin
            r = r + dr;
            c = c + dc;
            if (go && r >= 0 && r < board_dim && c >= 0 && c < board_dim) begin
                if (b[r * board_dim + c].bits.occupied &&
                    b[r * board_dim + c].bits.white == w) begin
                    n++;
                end else begin
                    go = 1'b0;
                end
            end else begin
                go = 1'b0;
            end
        end
        return n;
    endfunction

    // full line through p, p itself counted
    function automatic int line_len(board_t b, pos_t p, int dr, int dc, logic w);
        return side_run(b, p, dr, dc, w) + side_run(b, p, -dr, -dc, w) + 1;
    endfunction

    assign stone_white = board[placed_pos].bits.white;

    assign win_hit = line_len(board, placed_pos, 0, 1, stone_white) >= win_len  // horizontal
                  || line_len(board, placed_pos, 1, 0, stone_white) >= win_len  // vertical
                  || line_len(board, placed_pos, 1, 1, stone_white) >= win_len
                  || line_len(board, placed_pos, 1, -1, stone_white) >= win_len;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            black_win <= 1'b0;
            white_win <= 1'b0;
        end else if (placed && win_hit) begin
            if (stone_white) begin
                white_win <= 1'b1;
            end else begin
                black_win <= 1'b1;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the omok testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_omok -f vlog.f -o tb_omok_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_omok_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "no pass line in log"
    exit 1
fi
exit 0

/* vlog.f */
common/omok_board_pkg.sv
common/omok_rules_pkg.sv
rtl/cursor_ctrl.sv
rtl/board_store.sv
rules/forbidden_checker.sv
rules/win_detector.sv
rtl/omok_top.sv
bench/clk_gen.sv
bench/tb_omok.sv
